// File: list.f
verilog/pmp_csr_pkg.sv
verilog/pmp_check_pkg.sv
verilog/pmp_region_if.sv
verilog/pmp_stage_if.sv
verilog/pmp_csr.sv
verilog/pmp_capture.sv
verilog/pmp_match.sv
verilog/pmp_decide.sv
verilog/pmp_unit.sv
sim/pmp_unit_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing -j 0
TOP       = pmp_unit_tb
FILELIST  = list.f
PASS_MSG  = All checks passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build output"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf obj_dir

// File: sim/pmp_unit_tb.sv
`timescale 1ns/10ps

module pmp_unit_tb
  import pmp_csr_pkg::*, pmp_check_pkg::*;
();

  localparam int watchdog_cycles = 5000;  // the tests take about 700 cycles.

  logic clk = 1'b0;
  logic rst, csr_wren, csr_rden, check_req, check_ack, check_fault;
  logic [11:0] csr_waddr, csr_raddr;
  logic [31:0] csr_wdata, csr_rdata, check_addr;
  logic [3:0] check_cause;
  access_kind_t check_kind;
  priv_t check_priv;
  logic [7:0] shadow_cfg [4];
  logic [31:0] shadow_addr [4];
  int errors = 0;
  int checks = 0;

  pmp_unit pmp_unit_inst (.*);

  always #20 clk = ~clk;

  function automatic logic [11:0] pmpaddr_csr(input int i);
    return csr_pmpaddr0 + 12'(i);
  endfunction

  function automatic int trailing_ones(input logic [31:0] v);
    int n;
    n = 0;
    while (n < 32 && v[n]) begin
      n++;
    end
    return n;
  endfunction

  // an address is frozen by its own lock or by a locked tor entry just above.
  function automatic logic addr_frozen(input int n);
    logic above_tor;
    above_tor = 1'b0;
    if (n < 3) begin
      above_tor = shadow_cfg[n+1][7] && (shadow_cfg[n+1][4:3] == 2'b01);
    end
    return shadow_cfg[n][7] || above_tor;
  endfunction

  // returns {fault, cause} for one access against the shadow registers.
  function automatic logic [4:0] model_result(input logic [31:0] a, input access_kind_t k,
                                              input priv_t p);
    logic [63:0] word, top, low;
    logic [7:0] c;
    logic [3:0] cause;
    logic hit, perm, allow;
    int win, t;
    word = {34'd0, a[31:2]};
    win = -1;
    for (int i = 0; i < 4; i++) begin
      top = {32'd0, shadow_addr[i]};
      low = (i == 0) ? 64'd0 : {32'd0, shadow_addr[i-1]};
      t = trailing_ones(shadow_addr[i]) + 1;  // napot size is 2^t words.
      case (shadow_cfg[i][4:3])
        2'b01: hit = (low <= word) && (word < top);
        2'b10: hit = (word == top);
        2'b11: hit = (word >> t) == (top >> t);
        default: hit = 1'b0;
      endcase
      if (hit && win < 0) begin
        win = i;
      end
    end
    cause = (k == kind_fetch) ? 4'd1 : (k == kind_load) ? 4'd5 : 4'd7;
    if (win < 0) begin
      allow = (p == priv_machine);
    end else begin
      c = shadow_cfg[win];
      perm = (k == kind_fetch) ? c[2] : (k == kind_load) ? c[0] : c[1];
      allow = (!c[7] && p == priv_machine) ? 1'b1 : perm;
    end
    return allow ? 5'd0 : {1'b1, cause};
  endfunction

  task automatic shadow_write(input logic [11:0] a, input logic [31:0] d);
    logic [7:0] b;
    int n;
    if (a == csr_pmpcfg0) begin
      for (int i = 0; i < 4; i++) begin
        b = d[8*i +: 8];
        b[6:5] = 2'b00;
        b[1] = b[1] & b[0];  // no w without r.
        if (!shadow_cfg[i][7]) begin
          shadow_cfg[i] = b;
        end
      end
    end else if (a >= csr_pmpaddr0 && a <= csr_pmpaddr3) begin
      n = int'(a - csr_pmpaddr0);
      if (!addr_frozen(n)) begin
        shadow_addr[n] = d;
      end
    end
  endtask

  task automatic apply_reset();
    @(posedge clk);
    rst <= 1'b0;
    repeat (5) @(posedge clk);
    rst <= 1'b1;
    for (int i = 0; i < 4; i++) begin
      shadow_cfg[i] = 8'h00;
      shadow_addr[i] = 32'h0;
    end
  endtask

  task automatic csr_write(input logic [11:0] a, input logic [31:0] d);
    @(posedge clk);
    csr_wren  <= 1'b1;
    csr_waddr <= a;
    csr_wdata <= d;
    @(posedge clk);
    csr_wren <= 1'b0;
    shadow_write(a, d);
  endtask

  task automatic csr_read(input logic [11:0] a, output logic [31:0] d);
    @(posedge clk);
    csr_rden  <= 1'b1;
    csr_raddr <= a;
    @(negedge clk);
    d = csr_rdata;
    @(posedge clk);
    csr_rden <= 1'b0;
  endtask

  task automatic read_and_compare(input logic [11:0] a, input logic [31:0] exp);
    logic [31:0] d;
    csr_read(a, d);
    checks++;
    if (d !== exp) begin
      $display("Error at %0t: csr %h read %h, expected %h", $time, a, d, exp);
      errors++;
    end
  endtask

  task automatic do_check(input logic [31:0] a, input access_kind_t k, input priv_t p,
                          input logic exp_fault, input logic [3:0] exp_cause);
    int edges;
    logic seen;
    edges = 0;
    seen = 1'b0;
    @(posedge clk);
    check_req  <= 1'b1;
    check_addr <= a;
    check_kind <= k;
    check_priv <= p;
    while (!seen && edges < 10) begin
      @(posedge clk);
      edges++;
      @(negedge clk);
      seen = (check_ack === 1'b1);
    end
    checks++;
    if (!seen) begin
      $display("no ack for the check at address %h after %0d cycles", a, edges);
      errors++;
    end else begin
      if (edges != 3) begin
        $display("Error at %0t: ack after %0d edges, expected 3", $time, edges);
        errors++;
      end
      if (check_fault !== exp_fault || check_cause !== exp_cause) begin
        $display("Error at %0t: addr %h kind %0d priv %0d gave fault %b cause %0d, expected %b %0d",
                 $time, a, k, p, check_fault, check_cause, exp_fault, exp_cause);
        errors++;
      end
    end
    @(posedge clk);
    check_req <= 1'b0;
    @(negedge clk);
    checks++;
    if (seen && check_ack !== 1'b1) begin
      $display("Error at %0t: ack fell while req was still high", $time);
      errors++;
    end
    @(negedge clk);
    checks++;
    if (check_ack !== 1'b0) begin
      $display("Error at %0t: ack still high one edge after req fell", $time);
      errors++;
    end
  endtask

  task automatic check_model(input logic [31:0] a, input access_kind_t k, input priv_t p);
    logic [4:0] r;
    r = model_result(a, k, p);
    do_check(a, k, p, r[4], r[3:0]);
  endtask

  task automatic test_csr_rw();
    read_and_compare(csr_pmpcfg0, 32'h0);
    for (int i = 0; i < 4; i++) begin
      read_and_compare(pmpaddr_csr(i), 32'h0);
    end
    // pad bits set in every byte, w without r in bytes 0 and 3.
    csr_write(csr_pmpcfg0, 32'h6E6B_7F62);
    read_and_compare(csr_pmpcfg0, 32'h0C0B_1F00);
    for (int i = 0; i < 4; i++) begin
      csr_write(pmpaddr_csr(i), 32'hA5C3_0F00 ^ (32'(i) * 32'h1111_1111));
      read_and_compare(pmpaddr_csr(i), 32'hA5C3_0F00 ^ (32'(i) * 32'h1111_1111));
    end
    read_and_compare(12'h3A1, 32'h0);
    @(posedge clk);
    csr_raddr <= csr_pmpaddr3;  // rden stays low.
    @(negedge clk);
    checks++;
    if (csr_rdata !== 32'h0) begin
      $display("Error at %0t: rdata %h with rden low", $time, csr_rdata);
      errors++;
    end
    csr_write(csr_pmpcfg0, 32'h0);
  endtask

  task automatic test_modes();
    logic [31:0] probes [13] = '{32'h1000, 32'h1003, 32'h1004, 32'h0FFC, 32'h2000,
                                 32'h201C, 32'h2020, 32'h1FFC, 32'h4000, 32'h4FFC,
                                 32'h5000, 32'h3FFC, 32'h8000};
    csr_write(csr_pmpaddr0, 32'h0000_0400);  // na4 at 0x1000.
    csr_write(csr_pmpaddr1, 32'h0000_0803);  // napot 32 bytes at 0x2000.
    csr_write(csr_pmpaddr2, 32'h0000_1000);
    csr_write(csr_pmpaddr3, 32'h0000_1400);  // tor 0x4000 to 0x5000.
    csr_write(csr_pmpcfg0, 32'h0B07_1D11);
    foreach (probes[n]) begin
      for (int k = 0; k < 3; k++) begin
        check_model(probes[n], access_kind_t'(2'(k)), priv_user);
      end
    end
    check_model(32'h1000, kind_store, priv_machine);
  endtask

  task automatic test_priority();
    csr_write(csr_pmpaddr0, 32'h0000_0C07);  // 64 bytes at 0x3000, read only.
    csr_write(csr_pmpaddr1, 32'h0000_0C04);  // word 0x3010, rwx.
    csr_write(csr_pmpaddr2, 32'h0000_0DFF);  // 4 KiB at 0x3000, rwx.
    csr_write(csr_pmpcfg0, 32'h001F_1719);
    do_check(32'h3010, kind_store, priv_user, 1'b1, 4'd7);
    do_check(32'h3010, kind_load, priv_user, 1'b0, 4'd0);
    do_check(32'h3100, kind_store, priv_user, 1'b0, 4'd0);
    do_check(32'h9000, kind_load, priv_user, 1'b1, 4'd5);
    do_check(32'h9000, kind_fetch, priv_user, 1'b1, 4'd1);
    do_check(32'h9000, kind_store, priv_machine, 1'b0, 4'd0);
    check_model(32'h3040, kind_fetch, priv_user);
  endtask

  task automatic test_lock();
    csr_write(csr_pmpcfg0, 32'h0);
    csr_write(csr_pmpaddr1, 32'h0000_1800);
    csr_write(csr_pmpaddr2, 32'h0000_1C00);
    csr_write(csr_pmpcfg0, 32'h0089_0000);  // entry 2 locked tor, read only.
    csr_write(csr_pmpcfg0, 32'h001F_0000);
    read_and_compare(csr_pmpcfg0, 32'h0089_0000);
    csr_write(csr_pmpaddr2, 32'h0000_2000);
    read_and_compare(csr_pmpaddr2, 32'h0000_1C00);
    csr_write(csr_pmpaddr1, 32'h0);
    read_and_compare(csr_pmpaddr1, 32'h0000_1800);
    csr_write(csr_pmpaddr3, 32'h0000_1234);
    read_and_compare(csr_pmpaddr3, 32'h0000_1234);
    do_check(32'h6000, kind_load, priv_machine, 1'b0, 4'd0);
    do_check(32'h6000, kind_store, priv_machine, 1'b1, 4'd7);
    do_check(32'h6FFC, kind_fetch, priv_machine, 1'b1, 4'd1);
    do_check(32'h7000, kind_store, priv_machine, 1'b0, 4'd0);
    do_check(32'h5FFC, kind_store, priv_machine, 1'b0, 4'd0);
    do_check(32'h6800, kind_load, priv_user, 1'b0, 4'd0);
  endtask

  task automatic test_random_checks();
    logic [31:0] base;
    base = 32'h0;
    apply_reset();  // clears the lock left by the previous test.
    for (int i = 0; i < 4; i++) begin
      base = base + ($urandom & 32'h0000_03FF);  // rising bounds keep tor ranges open.
      csr_write(pmpaddr_csr(i), base);
    end
    csr_write(csr_pmpcfg0, $urandom & 32'h1F1F_1F1F);
    for (int n = 0; n < 40; n++) begin
      check_model($urandom & 32'h0000_3FFF, access_kind_t'(2'($urandom_range(0, 2))),
                  priv_t'(1'($urandom_range(0, 1))));
    end
  endtask

  initial begin
    void'($urandom(16));
    rst        <= 1'b0;
    csr_wren   <= 1'b0;
    csr_rden   <= 1'b0;
    csr_waddr  <= 12'h0;
    csr_raddr  <= 12'h0;
    csr_wdata  <= 32'h0;
    check_req  <= 1'b0;
    check_addr <= 32'h0;
    check_kind <= kind_fetch;
    check_priv <= priv_user;
    apply_reset();
    test_csr_rw();
    test_modes();
    test_priority();
    test_lock();
    test_random_checks();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    $display("timeout: the run did not finish within %0d cycles", watchdog_cycles);
    $display("Checks failed");
    $finish;
  end

endmodule

// File: verilog/pmp_unit.sv
`timescale 1ns/10ps

module pmp_unit
  import pmp_csr_pkg::*, pmp_check_pkg::*;
(
  input  logic         clk,
  input  logic         rst,
  input  logic         csr_wren,
  input  logic [11:0]  csr_waddr,
  input  logic [31:0]  csr_wdata,
  input  logic         csr_rden,
  input  logic [11:0]  csr_raddr,
  output logic [31:0]  csr_rdata,
  input  logic         check_req,
  input  logic [31:0]  check_addr,
  input  access_kind_t check_kind,
  input  priv_t        check_priv,
  output logic         check_ack,
  output logic         check_fault,
  output logic [3:0]   check_cause
);

  logic ack_done;

  pmp_region_if region_bus ();
  pmp_stage_if  cap_to_match ();
  pmp_stage_if  match_to_decide ();

  pmp_csr pmp_csr_inst (
    .clk       (clk),
    .rst       (rst),
    .csr_wren  (csr_wren),
    .csr_waddr (csr_waddr),
    .csr_wdata (csr_wdata),
    .csr_rden  (csr_rden),
    .csr_raddr (csr_raddr),
    .csr_rdata (csr_rdata),
    .region    (region_bus.source)
  );

  pmp_capture pmp_capture_inst (
    .clk        (clk),
    .rst        (rst),
    .check_req  (check_req),
    .check_addr (check_addr),
    .check_kind (check_kind),
    .check_priv (check_priv),
    .ack_done   (ack_done),
    .out        (cap_to_match.up),
    .check_ack  (check_ack)
  );

  pmp_match pmp_match_inst (
    .clk    (clk),
    .rst    (rst),
    .region (region_bus.sink),
    .in     (cap_to_match.down),
    .out    (match_to_decide.up)
  );

  pmp_decide pmp_decide_inst (
    .clk         (clk),
    .rst         (rst),
    .in          (match_to_decide.down),
    .check_req   (check_req),
    .ack_done    (ack_done),
    .check_fault (check_fault),
    .check_cause (check_cause)
  );

endmodule

// File: verilog/pmp_decide.sv
`timescale 1ns/10ps

module pmp_decide
  import pmp_csr_pkg::*, pmp_check_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  pmp_stage_if.down   in,
  input  logic        check_req,
  output logic        ack_done,
  output logic        check_fault,
  output logic [3:0]  check_cause
);

  pmp_cfg_t   win_cfg;
  logic       any_hit;
  logic       perm;
  logic       allow;
  logic [3:0] kind_cause;

  always_comb begin
    win_cfg = '0;
    any_hit = 1'b0;
    for (int i = pmp_entries - 1; i >= 0; i--) begin  // lowest index wins.
      if (in.match[i]) begin
        win_cfg = in.cfg[i];
        any_hit = 1'b1;
      end
    end
  end

  always_comb begin
    case (in.kind)
      kind_fetch: begin
        perm       = win_cfg.x;
        kind_cause = cause_fetch_fault;
      end
      kind_load: begin
        perm       = win_cfg.r;
        kind_cause = cause_load_fault;
      end
      default: begin
        perm       = win_cfg.w;
        kind_cause = cause_store_fault;
      end
    endcase
  end

  always_comb begin
    if (!any_hit) begin
      allow = (in.priv == priv_machine);
    end else if (!win_cfg.l && in.priv == priv_machine) begin
      allow = 1'b1;
    end else begin
      allow = perm;  // locked entries bind machine mode too.
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      ack_done    <= 1'b0;
      check_fault <= 1'b0;
      check_cause <= '0;
    end else if (in.valid) begin
      ack_done    <= 1'b1;
      check_fault <= !allow;
      check_cause <= allow ? 4'd0 : kind_cause;
    end else if (!check_req) begin
      ack_done    <= 1'b0;
      check_fault <= 1'b0;
      check_cause <= '0;
    end
  end

endmodule

// File: verilog/pmp_match.sv
`timescale 1ns/10ps

module pmp_match
  import pmp_csr_pkg::*, pmp_check_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  pmp_region_if.sink region,
  pmp_stage_if.down  in,
  pmp_stage_if.up    out
);

  logic [31:0]            word_addr;
  logic [pmp_entries-1:0] hit;

  assign word_addr = {2'b00, in.addr[31:2]};

  always_comb begin
    logic [31:0] prev;
    logic [31:0] napot_mask;
    prev = '0;  // entry 0 is bounded below by zero.
    for (int i = 0; i < pmp_entries; i++) begin
      // trailing ones and the first zero above them are don't care bits
      napot_mask = ~(region.addr[i] ^ (region.addr[i] + 32'd1));
      case (region.cfg[i].a)
        addr_tor: begin
          hit[i] = (prev <= word_addr) && (word_addr < region.addr[i]);
        end
        addr_na4: begin
          hit[i] = (word_addr == region.addr[i]);
        end
        addr_napot: begin
          hit[i] = ((word_addr ^ region.addr[i]) & napot_mask) == '0;
        end
        default: begin
          hit[i] = 1'b0;  // off.
        end
      endcase
      prev = region.addr[i];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst) begin
      out.valid <= 1'b0;
    end else begin
      out.valid <= in.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in.valid) begin
      out.addr  <= in.addr;
      out.kind  <= in.kind;
      out.priv  <= in.priv;
      out.match <= hit;
      out.cfg   <= region.cfg;  // cfg as seen at match time.
    end
  end

endmodule

// File: verilog/pmp_capture.sv
`timescale 1ns/10ps

module pmp_capture
  import pmp_check_pkg::*;
(
  input  logic         clk,
  input  logic         rst,
  input  logic         check_req,
  input  logic [31:0]  check_addr,
  input  access_kind_t check_kind,
  input  priv_t        check_priv,
  input  logic         ack_done,
  pmp_stage_if.up      out,
  output logic         check_ack
);

  logic busy;
  logic start;

  assign start = check_req && !busy;  // one sample per handshake.

  always_ff @(posedge clk) begin
    if (!rst) begin
      busy      <= 1'b0;
      out.valid <= 1'b0;
    end else begin
      busy      <= check_req;  // back to idle once req falls.
      out.valid <= start;
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      out.addr <= check_addr;
      out.kind <= check_kind;
      out.priv <= check_priv;
    end
  end

  // no match yet, cfg is sampled by the next stage.
  assign out.match = '0;
  assign out.cfg   = '0;

  assign check_ack = busy && ack_done;

endmodule

// File: verilog/pmp_csr.sv
`timescale 1ns/10ps

module pmp_csr
  import pmp_csr_pkg::*, pmp_check_pkg::*;
(
  input  logic         clk,
  input  logic         rst,
  input  logic         csr_wren,
  input  logic [11:0]  csr_waddr,
  input  logic [31:0]  csr_wdata,
  input  logic         csr_rden,
  input  logic [11:0]  csr_raddr,
  output logic [31:0]  csr_rdata,
  pmp_region_if.source region
);

  pmp_cfg_word_u                     pmpcfg;
  pmp_cfg_word_u                     wr_word;
  logic [pmp_entries-1:0] [31:0]     pmpaddr;
  logic [pmp_entries-1:0]            cfg_lock;
  logic [pmp_entries-1:0]            tor_lock;
  logic [pmp_entries-1:0]            addr_lock;

  // W without R is reserved, and the pad bits are hardwired to zero.
  function automatic pmp_cfg_t legalize(input pmp_cfg_t c);
    pmp_cfg_t v;
    v = c;
    v.pad = 2'b00;
    if (!c.r) begin
      v.w = 1'b0;
    end
    return v;
  endfunction

  assign wr_word.raw = csr_wdata;

  always_comb begin
    for (int i = 0; i < pmp_entries; i++) begin
      cfg_lock[i] = pmpcfg.entry[i].l;
      tor_lock[i] = pmpcfg.entry[i].l && (pmpcfg.entry[i].a == addr_tor);
    end
  end

  // an address is frozen by its own lock or by a locked tor entry above it.
  assign addr_lock = cfg_lock | (tor_lock >> 1);

  always_ff @(posedge clk) begin
    if (!rst) begin
      pmpcfg.raw <= '0;
      pmpaddr    <= '0;
    end else if (csr_wren) begin
      case (csr_waddr)
        csr_pmpcfg0: begin
          for (int i = 0; i < pmp_entries; i++) begin
            if (!cfg_lock[i]) begin
              pmpcfg.entry[i] <= legalize(wr_word.entry[i]);
            end
          end
        end
        csr_pmpaddr0: if (!addr_lock[0]) pmpaddr[0] <= csr_wdata;
        csr_pmpaddr1: if (!addr_lock[1]) pmpaddr[1] <= csr_wdata;
        csr_pmpaddr2: if (!addr_lock[2]) pmpaddr[2] <= csr_wdata;
        csr_pmpaddr3: if (!addr_lock[3]) pmpaddr[3] <= csr_wdata;
        default: ;
      endcase
    end
  end

  always_comb begin
    csr_rdata = '0;
    if (csr_rden) begin
      case (csr_raddr)
        csr_pmpcfg0:  csr_rdata = pmpcfg.raw;
        csr_pmpaddr0: csr_rdata = pmpaddr[0];
        csr_pmpaddr1: csr_rdata = pmpaddr[1];
        csr_pmpaddr2: csr_rdata = pmpaddr[2];
        csr_pmpaddr3: csr_rdata = pmpaddr[3];
        default:      csr_rdata = '0;  // unknown csr.
      endcase
    end
  end

  assign region.cfg  = pmpcfg.entry;
  assign region.addr = pmpaddr;

endmodule

// File: verilog/pmp_stage_if.sv
`timescale 1ns/10ps

interface pmp_stage_if
  import pmp_csr_pkg::*, pmp_check_pkg::*;
();

  logic                       valid;  // one cycle per check.
  logic [31:0]                addr;
  access_kind_t               kind;
  priv_t                      priv;
  logic [pmp_entries-1:0]     match;
  pmp_cfg_t [pmp_entries-1:0] cfg;

  modport up (
    output valid, addr, kind, priv, match, cfg
  );

  modport down (
    input valid, addr, kind, priv, match, cfg
  );

endinterface

// File: verilog/pmp_region_if.sv
`timescale 1ns/10ps

interface pmp_region_if
  import pmp_csr_pkg::*, pmp_check_pkg::*;
();

  pmp_cfg_t [pmp_entries-1:0]        cfg;
  logic     [pmp_entries-1:0] [31:0] addr;  // pmpaddr, address bits 33:2.

  modport source (
    output cfg,
    output addr
  );

  modport sink (
    input cfg,
    input addr
  );

endinterface

// File: verilog/pmp_check_pkg.sv
package pmp_check_pkg;

  localparam int pmp_entries = 4;

  typedef enum logic [1:0] {
    kind_fetch = 2'd0,
    kind_load  = 2'd1,
    kind_store = 2'd2
  } access_kind_t;

  typedef enum logic {
    priv_user    = 1'b0,
    priv_machine = 1'b1
  } priv_t;

  // mcause codes for access faults.
  localparam logic [3:0] cause_fetch_fault = 4'd1;
  localparam logic [3:0] cause_load_fault  = 4'd5;
  localparam logic [3:0] cause_store_fault = 4'd7;

endpackage

// File: verilog/pmp_csr_pkg.sv
package pmp_csr_pkg;

  localparam logic [11:0] csr_pmpcfg0  = 12'h3A0;
  localparam logic [11:0] csr_pmpaddr0 = 12'h3B0;
  localparam logic [11:0] csr_pmpaddr1 = 12'h3B1;
  localparam logic [11:0] csr_pmpaddr2 = 12'h3B2;
  localparam logic [11:0] csr_pmpaddr3 = 12'h3B3;

  // A field of a cfg byte
  localparam logic [1:0] addr_off   = 2'd0;
  localparam logic [1:0] addr_tor   = 2'd1;
  localparam logic [1:0] addr_na4   = 2'd2;
  localparam logic [1:0] addr_napot = 2'd3;

  typedef struct packed {
    logic       l;
    logic [1:0] pad;  // reads as zero.
    logic [1:0] a;
    logic       x;
    logic       w;
    logic       r;
  } pmp_cfg_t;

  // pmpcfg0 seen as a plain csr word or as four entry bytes, entry 0 lowest.
  typedef union packed {
    logic [31:0]    raw;
    pmp_cfg_t [3:0] entry;
  } pmp_cfg_word_u;

endpackage
